// File: Bender.yml
package:
  name: decode_unit

sources:
  - include_dirs:
      - .
    files:
      - decode_pkg.sv
      - inst_decoder.sv
      - inst_router.sv
      - issue_reg.sv
      - decode_unit.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_decode_unit.sv

// File: all.f
+incdir+.
decode_pkg.sv
inst_decoder.sv
inst_router.sv
issue_reg.sv
decode_unit.sv
tb_decode_unit.sv

// File: decode_input.txt
# name pc inst uop rd rs1 rs2 imm illegal pipe_mask, all hex but name
# uop 0 ADD 1 MUL 2 LW 3 SW 4 JAL 5 JALR 6 BNE, pipe_mask bit i is pipe i
# illegal rows carry zero fields and an empty mask
add_basic  00001000 002081b3 0 03 01 02 00000000 0 3
mul_basic  00001004 027302b3 1 05 06 07 00000000 0 2
lw_pos     00001008 00812203 2 04 02 00 00000008 0 4
sub_bad    0000100c 402081b3 0 00 00 00 00000000 1 0
lw_neg     00001010 ffc52083 2 01 0a 00 fffffffc 0 4
sw_pos     00001014 0051a623 3 00 03 05 0000000c 0 4
sw_neg     00001018 fe712c23 3 00 02 07 fffffff8 0 4
beq_bad    0000101c 00208463 0 00 00 00 00000000 1 0
jal_fwd    00001020 010000ef 4 01 00 00 00000010 0 1
jal_back   00001024 ff9ff06f 4 00 00 00 fffffff8 0 1
jalr_zero  00001028 000280e7 5 01 05 00 00000000 0 1
lb_bad     0000102c 00810203 0 00 00 00 00000000 1 0
jalr_neg   00001030 ff430067 5 00 06 00 fffffff4 0 1
bne_fwd    00001034 00209463 6 00 01 02 00000008 0 1
bne_back   00001038 fe4198e3 6 00 03 04 fffffff0 0 1
lui_bad    0000103c 123450b7 0 00 00 00 00000000 1 0
add_high   00001040 01df0fb3 0 1f 1e 1d 00000000 0 3
zero_bad   00001044 00000000 0 00 00 00 00000000 1 0
lw_max     00001048 7ff42483 2 09 08 00 000007ff 0 4
mul_same   0000104c 021080b3 1 01 01 01 00000000 0 2
add_zero   00001050 00000033 0 00 00 00 00000000 0 3
add_again  00001054 002081b3 0 03 01 02 00000000 0 3
add_last   00001058 01df0fb3 0 1f 1e 1d 00000000 0 3

// File: decode_pkg.sv
/*
 * Types shared by the decode stage.
 * Each micro-op value is also its bit position in rv_op_vec.
 */
package decode_pkg;

  // --------------------------------------------------
  // Micro-ops and subset vectors
  // --------------------------------------------------

  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_MUL  = 3'd1,
    OP_LW   = 3'd2,
    OP_SW   = 3'd3,
    OP_JAL  = 3'd4,
    OP_JALR = 3'd5,
    OP_BNE  = 3'd6
  } rv_uop;

  // One bit per micro-op
  typedef logic [6:0] rv_op_vec;

  localparam rv_op_vec OP_ADD_VEC  = 7'b000_0001;
  localparam rv_op_vec OP_MUL_VEC  = 7'b000_0010;
  localparam rv_op_vec OP_LW_VEC   = 7'b000_0100;
  localparam rv_op_vec OP_SW_VEC   = 7'b000_1000;
  localparam rv_op_vec OP_JAL_VEC  = 7'b001_0000;
  localparam rv_op_vec OP_JALR_VEC = 7'b010_0000;
  localparam rv_op_vec OP_BNE_VEC  = 7'b100_0000;
  localparam rv_op_vec OP_ALL_VEC  = 7'b111_1111;

  // --------------------------------------------------
  // RV32 major opcodes used by TinyRV1
  // --------------------------------------------------

  typedef enum logic [6:0] {
    OPC_OP     = 7'b011_0011,
    OPC_LOAD   = 7'b000_0011,
    OPC_STORE  = 7'b010_0011,
    OPC_BRANCH = 7'b110_0011,
    OPC_JALR   = 7'b110_0111,
    OPC_JAL    = 7'b110_1111
  } rv_opcode;

  // --------------------------------------------------
  // Messages
  // --------------------------------------------------

  // Fetch to decode
  typedef struct packed {
    logic [31:0] inst;
    logic [31:0] pc;
  } f_d_msg;

  // Decode to execute in 82 bits
  typedef struct packed {
    rv_uop       uop;
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    // Sign-extended immediate
    logic [31:0] imm;
  } d_x_msg;

endpackage

// File: decode_settings.svh
/*
 * Pipe count and per-pipe instruction subsets of the decode stage.
 * Subset macros refer to decode_pkg constants. Compile the package first.
 * The router holds subsets for at most four pipes.
 */
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// Number of execute pipes from 1 to 4
`define DECODE_NUM_PIPES 3

// Pipe 0 is the ALU with jumps and branches
`define DECODE_PIPE0_SUBSET (decode_pkg::OP_ADD_VEC | decode_pkg::OP_JAL_VEC | \
                             decode_pkg::OP_JALR_VEC | decode_pkg::OP_BNE_VEC)

// Pipe 1 is the multiplier that also takes adds
`define DECODE_PIPE1_SUBSET (decode_pkg::OP_MUL_VEC | decode_pkg::OP_ADD_VEC)

// Pipe 2 runs loads and stores
`define DECODE_PIPE2_SUBSET (decode_pkg::OP_LW_VEC | decode_pkg::OP_SW_VEC)

// Spare fourth pipe runs all of TinyRV1
`define DECODE_PIPE3_SUBSET (decode_pkg::OP_ALL_VEC)

`endif

// File: decode_unit.sv
/*
 * Decode stage top. Decoder, router and one issue register per pipe.
 * Two cycles of latency without back-pressure.
 * Order is kept within a pipe only.
 */
`timescale 1ns/1ps
`include "decode_settings.svh"

module decode_unit (
  input  logic                                       clk,
  input  logic                                       reset,
  input  logic                                       f_val,
  input  decode_pkg::f_d_msg                         f_msg,
  output logic                                       f_rdy,
  output logic               [`DECODE_NUM_PIPES-1:0] x_val,
  output decode_pkg::d_x_msg [`DECODE_NUM_PIPES-1:0] x_msg,
  input  logic               [`DECODE_NUM_PIPES-1:0] x_rdy,
  output logic                                       illegal
);

  import decode_pkg::*;

  // Decoder to router
  logic   d_val;
  logic   d_rdy;
  d_x_msg d_msg;

  // Router to issue registers
  logic [`DECODE_NUM_PIPES-1:0] route_val;
  logic [`DECODE_NUM_PIPES-1:0] route_rdy;

  inst_decoder inst_decoder_i (
    .clk     (clk),
    .reset   (reset),
    .f_val   (f_val),
    .f_msg   (f_msg),
    .f_rdy   (f_rdy),
    .d_val   (d_val),
    .d_msg   (d_msg),
    .d_rdy   (d_rdy),
    .illegal (illegal)
  );

  // Only the micro-op steers routing
  inst_router inst_router_i (
    .d_val     (d_val),
    .d_uop     (d_msg.uop),
    .d_rdy     (d_rdy),
    .route_val (route_val),
    .route_rdy (route_rdy)
  );

  // Same message offered to every pipe
  for (genvar i = 0; i < `DECODE_NUM_PIPES; i++) begin : g_pipe
    issue_reg issue_reg_i (
      .clk    (clk),
      .reset  (reset),
      .in_val (route_val[i]),
      .in_msg (d_msg),
      .in_rdy (route_rdy[i]),
      .x_val  (x_val[i]),
      .x_msg  (x_msg[i]),
      .x_rdy  (x_rdy[i])
    );
  end

endmodule

// File: inst_decoder.sv
/*
 * Fetch-to-decode register with TinyRV1 field decode.
 * Register fields a format does not use read as zero, as does imm for R-type.
 * Encodings outside TinyRV1 are dropped with a one-cycle illegal pulse.
 */
`timescale 1ns/1ps

module inst_decoder (
  input  logic               clk,
  input  logic               reset,
  input  logic               f_val,
  input  decode_pkg::f_d_msg f_msg,
  output logic               f_rdy,
  output logic               d_val,
  output decode_pkg::d_x_msg d_msg,
  input  logic               d_rdy,
  output logic               illegal
);

  import decode_pkg::*;

  // funct3 and funct7 values of TinyRV1
  localparam logic [2:0] F3_ZERO = 3'b000;
  localparam logic [2:0] F3_WORD = 3'b010;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [6:0] F7_ADD  = 7'b000_0000;
  localparam logic [6:0] F7_MUL  = 7'b000_0001;

  f_d_msg      fd_q;
  logic        full_q;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic        legal;
  rv_uop       uop;
  logic [31:0] imm;
  logic        use_rd;
  logic        use_rs1;
  logic        use_rs2;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_j;

  // --------------------------------------------------
  // Fetch-to-decode register
  // --------------------------------------------------

  // Loads while empty or while the current entry leaves
  assign f_rdy = !full_q || d_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      full_q <= 1'b0;
    end else if (f_rdy) begin
      full_q <= f_val;
    end
  end

  // Payload only
  always_ff @(posedge clk) begin
    if (f_val && f_rdy) begin
      fd_q <= f_msg;
    end
  end

  // --------------------------------------------------
  // Field decode
  // --------------------------------------------------

  assign funct3 = fd_q.inst[14:12];
  assign funct7 = fd_q.inst[31:25];

  // Immediates per format
  assign imm_i = {{20{fd_q.inst[31]}}, fd_q.inst[31:20]};
  assign imm_s = {{20{fd_q.inst[31]}}, fd_q.inst[31:25], fd_q.inst[11:7]};
  assign imm_b = {{19{fd_q.inst[31]}}, fd_q.inst[31], fd_q.inst[7],
                  fd_q.inst[30:25], fd_q.inst[11:8], 1'b0};
  assign imm_j = {{11{fd_q.inst[31]}}, fd_q.inst[31], fd_q.inst[19:12],
                  fd_q.inst[20], fd_q.inst[30:21], 1'b0};

  always_comb begin
    legal   = 1'b0;
    uop     = OP_ADD;
    imm     = '0;
    use_rd  = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (rv_opcode'(fd_q.inst[6:0]))
      OPC_OP: begin
        // ADD and MUL differ only in funct7
        if (funct3 == F3_ZERO && (funct7 == F7_ADD || funct7 == F7_MUL)) begin
          legal   = 1'b1;
          uop     = (funct7 == F7_MUL) ? OP_MUL : OP_ADD;
          use_rd  = 1'b1;
          use_rs1 = 1'b1;
          use_rs2 = 1'b1;
        end
      end
      OPC_LOAD: begin
        if (funct3 == F3_WORD) begin
          legal   = 1'b1;
          uop     = OP_LW;
          imm     = imm_i;
          use_rd  = 1'b1;
          use_rs1 = 1'b1;
        end
      end
      OPC_STORE: begin
        if (funct3 == F3_WORD) begin
          legal   = 1'b1;
          uop     = OP_SW;
          imm     = imm_s;
          use_rs1 = 1'b1;
          use_rs2 = 1'b1;
        end
      end
      OPC_BRANCH: begin
        if (funct3 == F3_BNE) begin
          legal   = 1'b1;
          uop     = OP_BNE;
          imm     = imm_b;
          use_rs1 = 1'b1;
          use_rs2 = 1'b1;
        end
      end
      OPC_JALR: begin
        if (funct3 == F3_ZERO) begin
          legal   = 1'b1;
          uop     = OP_JALR;
          imm     = imm_i;
          use_rd  = 1'b1;
          use_rs1 = 1'b1;
        end
      end
      OPC_JAL: begin
        legal  = 1'b1;
        uop    = OP_JAL;
        imm    = imm_j;
        use_rd = 1'b1;
      end
      default: begin
        legal = 1'b0;
      end
    endcase
  end

  always_comb begin
    d_msg.uop = uop;
    d_msg.pc  = fd_q.pc;
    d_msg.rd  = use_rd  ? fd_q.inst[11:7]  : 5'd0;
    d_msg.rs1 = use_rs1 ? fd_q.inst[19:15] : 5'd0;
    d_msg.rs2 = use_rs2 ? fd_q.inst[24:20] : 5'd0;
    d_msg.imm = imm;
  end

  // Illegal entries never reach the router and leave the same cycle
  assign d_val   = full_q && legal;
  assign illegal = full_q && !legal;

  // Offered micro-op held until the router takes it
  a_d_msg_stable: assert property (@(posedge clk) disable iff (reset)
    d_val && !d_rdy |=> d_val && $stable(d_msg));

endmodule

// File: inst_router.sv
/*
 * Priority router of one micro-op to one of up to four pipes.
 * Purely combinational. Only the claiming pipe sees route_val.
 * Pipe subsets come from the settings header.
 */
`timescale 1ns/1ps
`include "decode_settings.svh"

module inst_router (
  input  logic                         d_val,
  input  decode_pkg::rv_uop            d_uop,
  output logic                         d_rdy,
  output logic [`DECODE_NUM_PIPES-1:0] route_val,
  input  logic [`DECODE_NUM_PIPES-1:0] route_rdy
);

  import decode_pkg::*;

  localparam int NUM_PIPES = `DECODE_NUM_PIPES;

  // Subset table indexed by pipe
  localparam rv_op_vec PIPE_SUBSETS [0:3] = '{
    `DECODE_PIPE0_SUBSET,
    `DECODE_PIPE1_SUBSET,
    `DECODE_PIPE2_SUBSET,
    `DECODE_PIPE3_SUBSET
  };

  // Pipe i can run the current micro-op
  logic [NUM_PIPES-1:0] eligible;
  // Some pipe below index i is eligible and ready
  logic [NUM_PIPES:0]   found;

  if (NUM_PIPES < 1 || NUM_PIPES > 4) begin : g_bad_pipe_count
    $error("decode_unit supports 1 to 4 pipes");
  end

  // --------------------------------------------------
  // Per-pipe eligibility and priority chain
  // --------------------------------------------------

  assign found[0] = 1'b0;

  for (genvar i = 0; i < NUM_PIPES; i++) begin : g_pipe
    // Micro-op value selects its bit in the subset
    assign eligible[i] = PIPE_SUBSETS[i][d_uop];

    // First eligible ready pipe claims it
    assign route_val[i] = d_val && eligible[i] && route_rdy[i] && !found[i];

    assign found[i+1] = found[i] || (eligible[i] && route_rdy[i]);
  end

  // --------------------------------------------------
  // Back to the decoder
  // --------------------------------------------------

  // With d_val high the chain end is the OR of all transfers
  assign d_rdy = found[NUM_PIPES] || !d_val;

  // Every offered micro-op has a pipe that can run it
  a_uop_has_pipe: assert final (!d_val || (|eligible));

endmodule

// File: issue_reg.sv
/*
 * One-entry decode-to-execute register for one pipe.
 * Ready passes through from x_rdy so a full register can reload while
 * its entry leaves. Full throughput with one cycle of latency.
 */
`timescale 1ns/1ps

module issue_reg (
  input  logic               clk,
  input  logic               reset,
  input  logic               in_val,
  input  decode_pkg::d_x_msg in_msg,
  output logic               in_rdy,
  output logic               x_val,
  output decode_pkg::d_x_msg x_msg,
  input  logic               x_rdy
);

  import decode_pkg::*;

  logic   full_q;
  d_x_msg msg_q;

  // --------------------------------------------------
  // Occupancy
  // --------------------------------------------------

  // Empty, or the entry leaves on this edge
  assign in_rdy = !full_q || x_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      full_q <= 1'b0;
    end else if (in_rdy) begin
      full_q <= in_val;
    end
  end

  // --------------------------------------------------
  // Payload
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (in_val && in_rdy) begin
      msg_q <= in_msg;
    end
  end

  assign x_val = full_q;
  assign x_msg = msg_q;

  // Execute side sees a stable offer until it takes it
  a_x_hold: assert property (@(posedge clk) disable iff (reset)
    x_val && !x_rdy |=> x_val && $stable(x_msg));

endmodule

// File: tb_decode_unit.sv
/*
 * Testbench for decode_unit. Vectors come from decode_input.txt in the project root.
 * Pass 0 holds x_rdy high and pass 1 drives random x_rdy.
 * Each pass offsets the pcs so every pc in the run is unique.
 */
`timescale 1ns/1ps
`include "decode_settings.svh"

module tb_decode_unit;

  import decode_pkg::*;

  localparam int NP           = `DECODE_NUM_PIPES;
  localparam int CLK_PERIOD   = 4;
  localparam int NUM_PASSES   = 2;
  localparam int WATCH_CYCLES = 40;
  localparam int MAX_VEC      = 64;
  localparam logic [31:0] PASS_STRIDE = 32'h0001_0000;

  logic            clk;
  logic            reset;
  logic            f_val;
  f_d_msg          f_msg;
  logic            f_rdy;
  logic   [NP-1:0] x_val;
  d_x_msg [NP-1:0] x_msg;
  logic   [NP-1:0] x_rdy;
  logic            illegal;

  // Vector table
  string       vec_name [MAX_VEC];
  logic [31:0] vec_pc   [MAX_VEC];
  logic [31:0] vec_inst [MAX_VEC];
  d_x_msg      vec_exp  [MAX_VEC];
  logic        vec_ill  [MAX_VEC];
  rv_op_vec    vec_mask [MAX_VEC];
  int          nvec;
  int          legal_cnt;

  // Scoreboard keyed by pc
  int          idx_of    [logic [31:0]];
  int          seen      [logic [31:0]];
  int          ill_seen  [logic [31:0]];
  bit          bad_pc    [logic [31:0]];
  bit          order_bad [logic [31:0]];
  logic [31:0] last_pc   [NP];
  logic [31:0] dec_pc;
  logic [31:0] pass_base;
  int          n_left;

  logic        random_rdy;
  integer      seed = 32'h4a06ce17;
  int          errors;
  int          tests;
  int          failed;

  decode_unit dut_i (
    .clk     (clk),
    .reset   (reset),
    .f_val   (f_val),
    .f_msg   (f_msg),
    .f_rdy   (f_rdy),
    .x_val   (x_val),
    .x_msg   (x_msg),
    .x_rdy   (x_rdy),
    .illegal (illegal)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Execute side back-pressure changes just after each edge
  always @(posedge clk) begin
    #1;
    x_rdy = random_rdy ? NP'($random(seed)) : '1;
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  task automatic report_failure(input string what);
    $display("%s", what);
    errors++;
  endtask

  task automatic check_msg(input string name, input d_x_msg exp, input d_x_msg act);
    if (act !== exp) begin
      $display("ERR %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  // Strict mode wants the lowest pipe of the mask
  task automatic check_pipe(input string name, input rv_op_vec mask, input logic strict,
                            input int pipe);
    int want;
    want = -1;
    for (int i = 6; i >= 0; i--) begin
      if (mask[i]) want = i;
    end
    if (strict && pipe != want) begin
      $display("ERR %s: expected pipe %0d, actual pipe %0d", name, want, pipe);
      errors++;
    end else if (!mask[pipe]) begin
      $display("ERR %s: expected a pipe in mask %b, actual pipe %0d", name, mask, pipe);
      errors++;
    end
  endtask

  task automatic check_illegal(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s: expected illegal %b, actual illegal %b", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_reset_state();
    if (f_rdy !== 1'b1 || x_val !== '0 || illegal !== 1'b0) begin
      report_failure($sformatf("Reset state wrong, f_rdy %b x_val %b illegal %b",
                               f_rdy, x_val, illegal));
    end
  endtask

  // --------------------------------------------------
  // Monitor sampled at the falling edge
  // --------------------------------------------------

  task automatic take_exit(input int pipe, input d_x_msg act);
    int     k;
    int     e0;
    d_x_msg exp;
    e0 = errors;
    if (!idx_of.exists(act.pc)) begin
      report_failure($sformatf("Pipe %0d sent pc %h that was never fetched", pipe, act.pc));
    end else begin
      k = idx_of[act.pc];
      exp = vec_exp[k];
      exp.pc = vec_pc[k] + pass_base;
      check_msg(vec_name[k], exp, act);
      check_pipe(vec_name[k], vec_mask[k], !random_rdy, pipe);
      // Program order within one pipe
      if (act.pc <= last_pc[pipe]) order_bad[act.pc] = 1'b1;
      last_pc[pipe] = act.pc;
      seen[act.pc] = seen.exists(act.pc) ? seen[act.pc] + 1 : 1;
      n_left++;
      if (errors != e0) bad_pc[act.pc] = 1'b1;
    end
  endtask

  always @(negedge clk) begin
    if (!reset) begin
      // Pulse belongs to the entry now in the decode register
      if (illegal) begin
        ill_seen[dec_pc] = ill_seen.exists(dec_pc) ? ill_seen[dec_pc] + 1 : 1;
      end
      if (f_val && f_rdy) dec_pc = f_msg.pc;
      for (int i = 0; i < NP; i++) begin
        if (x_val[i] && x_rdy[i]) take_exit(i, x_msg[i]);
      end
    end
  end

  // --------------------------------------------------
  // Vectors and passes
  // --------------------------------------------------

  task automatic load_vectors();
    int          fd;
    int          code;
    string       line;
    string       name;
    logic [31:0] col [9];
    fd = $fopen("decode_input.txt", "r");
    if (fd == 0) return;
    while (!$feof(fd) && nvec < MAX_VEC) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line[0] != "#") begin
        code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h", name, col[0], col[1],
                       col[2], col[3], col[4], col[5], col[6], col[7], col[8]);
        if (code == 10) begin
          vec_name[nvec]    = name;
          vec_pc[nvec]      = col[0];
          vec_inst[nvec]    = col[1];
          vec_exp[nvec].uop = rv_uop'(col[2][2:0]);
          vec_exp[nvec].pc  = col[0];
          vec_exp[nvec].rd  = col[3][4:0];
          vec_exp[nvec].rs1 = col[4][4:0];
          vec_exp[nvec].rs2 = col[5][4:0];
          vec_exp[nvec].imm = col[6];
          vec_ill[nvec]     = col[7][0];
          vec_mask[nvec]    = col[8][6:0];
          for (int p = 0; p < NUM_PASSES; p++) idx_of[col[0] + PASS_STRIDE * p] = nvec;
          if (!col[7][0]) legal_cnt++;
          nvec++;
        end
      end
    end
    $fclose(fd);
  endtask

  // One line per vector once its pass has drained
  task automatic tally_pass(input int pass);
    logic [31:0] p;
    int          e0;
    int          n_ill;
    int          n_out;
    for (int v = 0; v < nvec; v++) begin
      p = vec_pc[v] + pass_base;
      e0 = errors;
      n_ill = ill_seen.exists(p) ? ill_seen[p] : 0;
      n_out = seen.exists(p) ? seen[p] : 0;
      check_illegal(vec_name[v], vec_ill[v], n_ill != 0);
      if (n_ill > 1) report_failure($sformatf("%s raised illegal %0d times", vec_name[v], n_ill));
      if (vec_ill[v] && n_out != 0) begin
        report_failure($sformatf("%s is illegal but left on a pipe", vec_name[v]));
      end
      if (!vec_ill[v] && n_out != 1) begin
        report_failure($sformatf("%s left the pipes %0d times", vec_name[v], n_out));
      end
      if (order_bad.exists(p)) begin
        report_failure($sformatf("%s left its pipe out of program order", vec_name[v]));
      end
      tests++;
      if (errors != e0 || bad_pc.exists(p)) begin
        failed++;
        $display("test %s pass %0d: FAILED", vec_name[v], pass);
      end else begin
        $display("test %s pass %0d: ok", vec_name[v], pass);
      end
    end
  endtask

  // Entered and left just after a rising edge
  task automatic run_pass(input int pass);
    pass_base  = PASS_STRIDE * pass;
    random_rdy = (pass == 1);
    n_left     = 0;
    for (int v = 0; v < nvec; v++) begin
      f_val      = 1'b1;
      f_msg.inst = vec_inst[v];
      f_msg.pc   = vec_pc[v] + pass_base;
      @(negedge clk);
      while (!f_rdy) @(negedge clk);
      @(posedge clk);
      #1;
    end
    f_val = 1'b0;
    wait (n_left == legal_cnt);
    // Room for a late illegal pulse
    repeat (2) @(posedge clk);
    #1;
    tally_pass(pass);
  endtask

  initial begin
    wait (nvec > 0);
    #(WATCH_CYCLES * nvec * NUM_PASSES * CLK_PERIOD + 20 * CLK_PERIOD);
    $display("Timeout: the DUT stopped delivering instructions at %0t", $time);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    reset      = 1'b1;
    f_val      = 1'b0;
    f_msg      = '0;
    x_rdy      = '1;
    random_rdy = 1'b0;
    dec_pc     = '0;
    pass_base  = '0;
    for (int i = 0; i < NP; i++) last_pc[i] = '0;
    load_vectors();
    // Reset held for three edges and checked during and after
    repeat (2) begin
      @(posedge clk);
      @(negedge clk);
      check_reset_state();
    end
    @(posedge clk);
    #1;
    reset = 1'b0;
    @(negedge clk);
    check_reset_state();
    @(posedge clk);
    #1;
    if (nvec == 0) begin
      report_failure("No vectors could be read from decode_input.txt");
    end else begin
      for (int pass = 0; pass < NUM_PASSES; pass++) run_pass(pass);
    end
    $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
